//--- dataframe.f
+incdir+design
design/dataframe_pkg.sv
design/sync_fifo.sv
design/frame_req_wb.sv
design/dataframe_gen.sv
design/axis_out_stage.sv
design/dataframe_top.sv
sim/tb_clock.sv
sim/dataframe_tb.sv

//--- design/axis_out_stage.sv
`default_nettype none
`timescale 1ns/1ps

module axis_out_stage (
    input  wire                           ACLK,
    input  wire                           ARESET,
    input  wire                           in_valid,
    input  wire dataframe_pkg::axis_beat_t in_beat,
    output logic                          in_ready,
    output logic                          m_axis_tvalid,
    output dataframe_pkg::beat_t          m_axis_tdata,
    output dataframe_pkg::keep_t          m_axis_tkeep,
    output logic                          m_axis_tlast,
    input  wire                           m_axis_tready
);
    import dataframe_pkg::*;

    axis_beat_t main_beat;
    axis_beat_t skid_beat;
    logic       main_valid;
    logic       skid_valid;
    logic       in_fire;
    logic       main_free;

    assign in_ready  = !skid_valid;   // Registered, low only with both entries full
    assign in_fire   = in_valid && in_ready;
    assign main_free = !main_valid || m_axis_tready;

    always_ff @(posedge ACLK) begin
        if (ARESET) begin
            main_valid <= 1'b0;
            skid_valid <= 1'b0;
        end else if (main_free) begin
            if (skid_valid) begin
                skid_valid <= 1'b0;   // Drain skid first to keep order
            end else begin
                main_valid <= in_fire;
            end
        end else if (in_fire) begin
            skid_valid <= 1'b1;
        end
    end

    always_ff @(posedge ACLK) begin
        if (main_free) begin
            main_beat <= skid_valid ? skid_beat : in_beat;
        end else if (in_fire) begin
            skid_beat <= in_beat;
        end
    end

    assign m_axis_tvalid = main_valid;
    assign m_axis_tdata  = main_beat.data;
    assign m_axis_tkeep  = main_beat.keep;
    assign m_axis_tlast  = main_beat.last;

endmodule

`default_nettype wire

//--- design/dataframe_consts.svh
`ifndef DATAFRAME_CONSTS_SVH
`define DATAFRAME_CONSTS_SVH

// Frame line and stream beat widths
`define DF_LINE_W 16
`define DF_BEAT_W 32

// Descriptor field widths, chan_id and frame_len share the low header line
`define DF_LEN_W 12
`define DF_CHAN_W 4

`define DF_DESC_DEPTH 8
`define DF_SAMPLE_DEPTH 64

// Wishbone word addresses
`define DF_ADDR_CTRL 2'd0
`define DF_ADDR_TAG 2'd1
`define DF_ADDR_STATUS 2'd2

`endif

//--- design/dataframe_gen.sv
`default_nettype none
`timescale 1ns/1ps

module dataframe_gen (
    input  wire                         ACLK,
    input  wire                         ARESET,
    input  wire                         desc_empty,
    input  wire dataframe_pkg::frame_desc_t desc,
    output logic                        desc_rd,
    input  wire                         sample_empty,
    input  wire dataframe_pkg::beat_t   sample,
    output logic                        sample_rd,
    output logic                        beat_valid,
    output dataframe_pkg::axis_beat_t   beat,
    input  wire                         beat_ready,
    output logic                        gen_error
);
    import dataframe_pkg::*;

    gen_state_t state;
    gen_state_t state_nxt;
    frame_len_t beat_cnt;        // Sample beats sent in this frame
    logic       beat_fire;
    logic       last_sample;

    assign beat_fire   = beat_valid && beat_ready;
    assign last_sample = (beat_cnt == frame_len_t'(desc.frame_len - 1'b1));

    // ------------------------------------------------------------------
    // Beat offered to the output stage
    // ------------------------------------------------------------------
    always_comb begin
        beat_valid = 1'b0;
        beat.data  = '0;
        beat.keep  = '1;
        beat.last  = 1'b0;
        case (state)
            HEADER: begin
                beat_valid = 1'b1;
                // Low line chan and length, high line sequence
                beat.data  = {desc.seq, desc.chan_id, desc.frame_len};
            end
            SAMPLES: begin
                beat_valid = !sample_empty;   // Stall on an empty sample FIFO
                beat.data  = sample;
            end
            FOOTER: begin
                beat_valid = 1'b1;
                beat.data  = {line_t'('1), desc.tag};
                beat.keep  = keep_t'(2'b11);  // Only the tag line is kept
                beat.last  = 1'b1;
            end
            default: begin
                beat_valid = 1'b0;
            end
        endcase
    end

    assign sample_rd = (state == SAMPLES) && beat_fire;
    assign desc_rd   = (state == FOOTER) && beat_fire;   // Descriptor retired with footer

    // ------------------------------------------------------------------
    // FSM
    // ------------------------------------------------------------------
    always_comb begin
        state_nxt = state;
        case (state)
            IDLE: begin
                if (!desc_empty) begin
                    state_nxt = sample_empty ? HALT : HEADER;
                end
            end
            HEADER: begin
                if (beat_fire) begin
                    state_nxt = SAMPLES;
                end
            end
            SAMPLES: begin
                if (beat_fire && last_sample) begin
                    state_nxt = FOOTER;
                end
            end
            FOOTER: begin
                if (beat_fire) begin
                    state_nxt = IDLE;
                end
            end
            HALT:    state_nxt = HALT;   // Only reset leaves
            default: state_nxt = IDLE;
        endcase
    end

    always_ff @(posedge ACLK) begin
        if (ARESET) begin
            state     <= IDLE;
            beat_cnt  <= '0;
            gen_error <= 1'b0;
        end else begin
            state <= state_nxt;
            if (state == HEADER) begin
                beat_cnt <= '0;
            end else if (sample_rd) begin
                beat_cnt <= beat_cnt + 1'b1;
            end
            if ((state == IDLE) && (state_nxt == HALT)) begin
                gen_error <= 1'b1;
            end
        end
    end

    // A frame in progress keeps its descriptor at the FIFO head
    assert property (@(posedge ACLK) disable iff (ARESET)
        (state inside {HEADER, SAMPLES, FOOTER}) |-> !desc_empty)
        else $error("dataframe_gen: frame in progress without a descriptor");

    // Header and footer come from the descriptor head, samples from the FIFO head
    assert property (@(posedge ACLK) disable iff (ARESET)
        beat_valid && !beat_ready |=> beat_valid && $stable(beat))
        else $error("dataframe_gen: beat changed while stalled");

endmodule

`default_nettype wire

//--- design/dataframe_pkg.sv
`default_nettype none

`include "dataframe_consts.svh"

package dataframe_pkg;

    typedef logic [`DF_LINE_W-1:0] line_t;
    typedef logic [`DF_BEAT_W-1:0] beat_t;        // Also one sample word, two lines
    typedef logic [`DF_BEAT_W/8-1:0] keep_t;
    typedef logic [`DF_LEN_W-1:0] frame_len_t;    // Sample beats per frame
    typedef logic [`DF_CHAN_W-1:0] chan_id_t;
    typedef logic [`DF_LINE_W-1:0] seq_t;

    // One queued frame request, 48 bits
    typedef struct packed {
        seq_t       seq;
        chan_id_t   chan_id;
        frame_len_t frame_len;
        line_t      tag;
    } frame_desc_t;

    typedef struct packed {
        beat_t data;
        keep_t keep;
        logic  last;
    } axis_beat_t;

    typedef enum logic [2:0] {IDLE, HEADER, SAMPLES, FOOTER, HALT} gen_state_t;

endpackage

`default_nettype wire

//--- design/dataframe_top.sv
`default_nettype none
`timescale 1ns/1ps

`include "dataframe_consts.svh"

module dataframe_top (
    input  wire                       ACLK,
    input  wire                       ARESET,
    input  wire                       wb_cyc,
    input  wire                       wb_stb,
    input  wire                       wb_we,
    input  wire  [1:0]                wb_adr,
    input  wire dataframe_pkg::beat_t wb_dat_i,
    output dataframe_pkg::beat_t      wb_dat_o,
    output logic                      wb_ack,
    input  wire                       adc_valid,
    input  wire dataframe_pkg::beat_t adc_data,
    output logic                      m_axis_tvalid,
    output dataframe_pkg::beat_t      m_axis_tdata,
    output dataframe_pkg::keep_t      m_axis_tkeep,
    output logic                      m_axis_tlast,
    input  wire                       m_axis_tready
);
    import dataframe_pkg::*;

    frame_desc_t desc_in;
    frame_desc_t desc_head;
    logic        desc_push;
    logic        desc_full;
    logic        desc_rd;
    logic        desc_empty;
    beat_t       sample_head;
    logic        sample_full;
    logic        sample_rd;
    logic        sample_empty;
    axis_beat_t  gen_beat;
    logic        gen_beat_valid;
    logic        gen_beat_ready;
    logic        gen_error;
    logic        overflow;

    // ------------------------------------------------------------------
    // Input side
    // ------------------------------------------------------------------
    frame_req_wb u_req (
        .ACLK(ACLK), .ARESET(ARESET),
        .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
        .wb_dat_i(wb_dat_i), .wb_dat_o(wb_dat_o), .wb_ack(wb_ack),
        .desc_push(desc_push), .desc(desc_in), .desc_full(desc_full),
        .overflow(overflow), .gen_error(gen_error)
    );

    sync_fifo #(.WIDTH($bits(frame_desc_t)), .DEPTH(`DF_DESC_DEPTH)) desc_fifo (
        .ARESET(ARESET), .ACLK(ACLK),
        .wr_en(desc_push), .wr_data(desc_in), .full(desc_full),
        .rd_en(desc_rd), .rd_data(desc_head), .empty(desc_empty)
    );

    sync_fifo #(.WIDTH(`DF_BEAT_W), .DEPTH(`DF_SAMPLE_DEPTH)) sample_fifo (
        .ARESET(ARESET), .ACLK(ACLK),
        .wr_en(adc_valid), .wr_data(adc_data), .full(sample_full),
        .rd_en(sample_rd), .rd_data(sample_head), .empty(sample_empty)
    );

    always_ff @(posedge ACLK) begin
        if (ARESET) begin
            overflow <= 1'b0;
        end else if (adc_valid && sample_full) begin
            overflow <= 1'b1;   // Sticky, the word is lost
        end
    end

    // ------------------------------------------------------------------
    // Assembler and output side
    // ------------------------------------------------------------------
    dataframe_gen u_gen (
        .ACLK(ACLK), .ARESET(ARESET),
        .desc_empty(desc_empty), .desc(desc_head), .desc_rd(desc_rd),
        .sample_empty(sample_empty), .sample(sample_head), .sample_rd(sample_rd),
        .beat_valid(gen_beat_valid), .beat(gen_beat), .beat_ready(gen_beat_ready),
        .gen_error(gen_error)
    );

    axis_out_stage u_out (
        .ACLK(ACLK), .ARESET(ARESET),
        .in_valid(gen_beat_valid), .in_beat(gen_beat), .in_ready(gen_beat_ready),
        .m_axis_tvalid(m_axis_tvalid), .m_axis_tdata(m_axis_tdata),
        .m_axis_tkeep(m_axis_tkeep), .m_axis_tlast(m_axis_tlast),
        .m_axis_tready(m_axis_tready)
    );

endmodule

`default_nettype wire

//--- design/frame_req_wb.sv
`default_nettype none
`timescale 1ns/1ps

`include "dataframe_consts.svh"

module frame_req_wb (
    input  wire                         ACLK,
    input  wire                         ARESET,
    input  wire                         wb_cyc,
    input  wire                         wb_stb,
    input  wire                         wb_we,
    input  wire  [1:0]                  wb_adr,
    input  wire dataframe_pkg::beat_t   wb_dat_i,
    output dataframe_pkg::beat_t        wb_dat_o,
    output logic                        wb_ack,
    output logic                        desc_push,
    output dataframe_pkg::frame_desc_t  desc,
    input  wire                         desc_full,
    input  wire                         overflow,
    input  wire                         gen_error
);
    import dataframe_pkg::*;

    chan_id_t   chan_q;
    frame_len_t len_q;
    line_t      tag_q;
    seq_t       seq_q;
    logic       done_q;      // Access served, wait for stb low
    logic       push_q;
    logic       desc_drop;
    logic       req;
    logic       wr_ctrl;
    logic       wr_tag;

    assign req     = wb_cyc && wb_stb && !done_q;
    assign wr_ctrl = req && wb_we && (wb_adr == `DF_ADDR_CTRL);
    assign wr_tag  = req && wb_we && (wb_adr == `DF_ADDR_TAG);

    // ------------------------------------------------------------------
    // Bus handshake and descriptor control
    // ------------------------------------------------------------------
    always_ff @(posedge ACLK) begin
        if (ARESET) begin
            wb_ack    <= 1'b0;
            done_q    <= 1'b0;
            push_q    <= 1'b0;
            seq_q     <= '0;
            desc_drop <= 1'b0;
            chan_q    <= '0;
            len_q     <= '0;
        end else begin
            wb_ack <= req;
            if (req) begin
                done_q <= 1'b1;
            end else if (!wb_stb) begin
                done_q <= 1'b0;
            end
            push_q <= wr_tag && (len_q != '0);   // Zero length never queued
            if (push_q) begin
                if (desc_full) begin
                    desc_drop <= 1'b1;
                end else begin
                    seq_q <= seq_q + 1'b1;
                end
            end
            if (wr_ctrl) begin
                chan_q <= wb_dat_i[`DF_CHAN_W+`DF_LEN_W-1:`DF_LEN_W];
                len_q  <= wb_dat_i[`DF_LEN_W-1:0];
            end
        end
    end

    always_ff @(posedge ACLK) begin
        if (wr_tag) begin
            tag_q <= wb_dat_i[`DF_LINE_W-1:0];
        end
        if (req) begin
            case (wb_adr)
                `DF_ADDR_CTRL:   wb_dat_o <= beat_t'({chan_q, len_q});
                `DF_ADDR_TAG:    wb_dat_o <= beat_t'(tag_q);
                `DF_ADDR_STATUS: wb_dat_o <= beat_t'({desc_drop, overflow, gen_error});
                default:         wb_dat_o <= '0;
            endcase
        end
    end

    assign desc_push = push_q && !desc_full;
    assign desc      = '{seq: seq_q, chan_id: chan_q, frame_len: len_q, tag: tag_q};

endmodule

`default_nettype wire

//--- design/sync_fifo.sv
`default_nettype none
`timescale 1ns/1ps

module sync_fifo #(
    parameter int WIDTH = 32,
    parameter int DEPTH = 8
) (
    input  wire              ARESET,
    input  wire              ACLK,
    input  wire              wr_en,
    input  wire  [WIDTH-1:0] wr_data,
    output logic             full,
    input  wire              rd_en,
    output logic [WIDTH-1:0] rd_data,
    output logic             empty
);

    localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    logic [WIDTH-1:0] mem [DEPTH];
    logic [AW-1:0]    wr_ptr;
    logic [AW-1:0]    rd_ptr;
    logic [AW:0]      count;
    logic             do_wr;
    logic             do_rd;

    assign full  = (count == (AW+1)'(DEPTH));
    assign empty = (count == '0);
    assign do_wr = wr_en && !full;   // Writes into a full FIFO are lost
    assign do_rd = rd_en && !empty;

    assign rd_data = mem[rd_ptr];    // Head word visible without a pop

    always_ff @(posedge ACLK) begin
        if (do_wr) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    always_ff @(posedge ACLK) begin
        if (ARESET) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= (wr_ptr == AW'(DEPTH-1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= (rd_ptr == AW'(DEPTH-1)) ? '0 : rd_ptr + 1'b1;
            end
            count <= count + (AW+1)'(do_wr) - (AW+1)'(do_rd);
        end
    end

    assert property (@(posedge ACLK) disable iff (ARESET) rd_en |-> !empty)
        else $error("sync_fifo: pop while empty");

endmodule

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
# Build and run the frame generator testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module dataframe_tb -f dataframe.f -o dataframe_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

sim_out=$(./obj_dir/dataframe_sim 2>&1)
sim_status=$?
printf '%s\n' "$sim_out"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
fi

# Pass only when the testbench printed its pass line
if printf '%s\n' "$sim_out" | grep -qx "Everything OK"; then
    exit 0
fi
exit 1

//--- sim/dataframe_tb.sv
`default_nettype none
`timescale 1ns/1ps

`include "dataframe_consts.svh"

module dataframe_tb;
    import dataframe_pkg::*;

    localparam int CLK_NS       = 4;
    localparam int NUM_FRAMES   = 13;
    localparam int WD_MARGIN_NS = 12000;

    logic        ACLK;
    logic        ARESET;
    logic        wb_cyc;
    logic        wb_stb;
    logic        wb_we;
    logic [1:0]  wb_adr;
    beat_t       wb_dat_i;
    beat_t       wb_dat_o;
    logic        wb_ack;
    logic        adc_valid;
    beat_t       adc_data;
    logic        m_axis_tvalid;
    beat_t       m_axis_tdata;
    keep_t       m_axis_tkeep;
    logic        m_axis_tlast;
    logic        m_axis_tready;

    logic [15:0] rng_state;
    logic [15:0] stall_rng;
    logic        stall_en;
    logic        wd_armed = 1'b0;
    int          wd_limit_ns;
    int          frame_len_tab [NUM_FRAMES];
    seq_t        model_seq;
    frame_desc_t exp_desc_q [$];      // Frames the stream still owes
    beat_t       exp_sample_q [$];
    int          beat_idx;            // Position inside the current frame
    logic        held;
    axis_beat_t  exp_beat;

    tb_clock #(.PERIOD_NS(CLK_NS)) clk_gen (.clk(ACLK));

    dataframe_top dut0 (
        .ACLK(ACLK), .ARESET(ARESET),
        .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
        .wb_dat_i(wb_dat_i), .wb_dat_o(wb_dat_o), .wb_ack(wb_ack),
        .adc_valid(adc_valid), .adc_data(adc_data),
        .m_axis_tvalid(m_axis_tvalid), .m_axis_tdata(m_axis_tdata),
        .m_axis_tkeep(m_axis_tkeep), .m_axis_tlast(m_axis_tlast),
        .m_axis_tready(m_axis_tready)
    );

    // ------------------------------------------------------------------
    // Random numbers and reference model
    // ------------------------------------------------------------------
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        logic [15:0] n;
        n = s >> 1;
        if (s[0]) begin
            n = n ^ 16'hB400;
        end
        return n;
    endfunction

    function automatic logic [31:0] rand_bits(input int count);
        logic [31:0] v;
        int          i;
        v = '0;
        for (i = 0; i < count; i++) begin
            v = {v[30:0], rng_state[0]};
            rng_state = lfsr_next(rng_state);
        end
        return v;
    endfunction

    // Index 0 is the header, then the samples, then the footer
    function automatic axis_beat_t expected_beat(input frame_desc_t d, input beat_t samples [$],
                                                 input int idx);
        axis_beat_t b;
        line_t      hdr_low;
        hdr_low = {d.chan_id, d.frame_len};
        b.keep  = 4'b1111;
        b.last  = 1'b0;
        if (idx == 0) begin
            b.data = {d.seq, hdr_low};
        end else if (idx <= int'(d.frame_len)) begin
            b.data = samples[idx - 1];
        end else begin
            b.data = {16'hFFFF, d.tag};
            b.keep = 4'b0011;
            b.last = 1'b1;
        end
        return b;
    endfunction

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("Something failed");
        $fatal(1);
    endtask

    task automatic check_val(input string name, input logic [63:0] got,
                             input logic [63:0] expected);
        if (got !== expected) begin
            report_failure($sformatf("[ERROR] %0t: %s got 0x%0h, expected 0x%0h",
                                     $time, name, got, expected));
        end
    endtask

    // ------------------------------------------------------------------
    // Stimulus tasks
    // ------------------------------------------------------------------
    task automatic wait_cycles(input int n);
        repeat (n) @(posedge ACLK);
        #1;
    endtask

    task automatic apply_reset();
        ARESET = 1'b1;
        exp_desc_q.delete();
        exp_sample_q.delete();
        model_seq = '0;
        repeat (2) @(posedge ACLK);
        #1;
        ARESET = 1'b0;
    endtask

    task automatic wb_access(input logic we, input logic [1:0] adr, input beat_t wdata,
                             output beat_t rdata);
        int waited;
        waited   = 0;
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = we;
        wb_adr   = adr;
        wb_dat_i = wdata;
        do begin
            @(posedge ACLK);
            #1;
            waited++;
            if (waited > 16) begin
                report_failure("Wishbone access got no ack within 16 cycles");
            end
        end while (!wb_ack);
        rdata  = wb_dat_o;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
        wait_cycles(1);     // Slave needs stb low before the next access
    endtask

    task automatic write_samples(input int count);
        beat_t word;
        int    i;
        for (i = 0; i < count; i++) begin
            word      = rand_bits(32);
            adc_valid = 1'b1;
            adc_data  = word;
            exp_sample_q.push_back(word);
            wait_cycles(1);
        end
        adc_valid = 1'b0;
    endtask

    task automatic queue_frame(input chan_id_t chan, input frame_len_t len, input line_t tag,
                               input logic expect_out);
        beat_t unused_rd;
        wb_access(1'b1, `DF_ADDR_CTRL, beat_t'({chan, len}), unused_rd);
        if (len != '0) begin   // Zero length takes no sequence number
            if (expect_out) begin
                exp_desc_q.push_back('{seq: model_seq, chan_id: chan, frame_len: len, tag: tag});
            end
            model_seq = model_seq + seq_t'(1);
        end
        wb_access(1'b1, `DF_ADDR_TAG, beat_t'(tag), unused_rd);
    endtask

    task automatic wait_frames_done();
        while (exp_desc_q.size() != 0) begin
            wait_cycles(1);
        end
        wait_cycles(2);
    endtask

    // Samples for the whole batch go in first so the generator never idles on an empty FIFO
    task automatic run_batch(input int first, input int count);
        int       total;
        int       k;
        chan_id_t chan;
        line_t    tag;
        total = 0;
        for (k = first; k < first + count; k++) begin
            total += frame_len_tab[k];
        end
        write_samples(total);
        for (k = first; k < first + count; k++) begin
            chan = chan_id_t'(rand_bits(4));
            tag  = line_t'(rand_bits(16));
            queue_frame(chan, frame_len_tab[k][`DF_LEN_W-1:0], tag, 1'b1);
        end
        wait_frames_done();
    endtask

    task automatic choose_lengths();
        int k;
        wd_limit_ns = WD_MARGIN_NS;
        for (k = 0; k < NUM_FRAMES; k++) begin
            if (k >= 1 && k <= 5) begin
                frame_len_tab[k] = 1 + int'(rand_bits(4)) % 12;   // Five frames fit in 64 words
            end else begin
                frame_len_tab[k] = 1 + int'(rand_bits(5)) % 20;
            end
            wd_limit_ns += (frame_len_tab[k] + 2) * 4 * CLK_NS;
        end
    endtask

    // ------------------------------------------------------------------
    // Stream monitor, tready pattern and watchdog
    // ------------------------------------------------------------------
    always @(negedge ACLK) begin : stream_monitor
        int k;
        if (ARESET) begin
            beat_idx = 0;
            held     = 1'b0;
        end else begin
            if (held) begin
                check_val("m_axis_tvalid", 64'(m_axis_tvalid), 64'd1);
            end
            if (!m_axis_tvalid) begin
                held = 1'b0;
            end else if (exp_desc_q.size() == 0) begin
                report_failure("tvalid raised with no frame outstanding");
            end else begin
                exp_beat = expected_beat(exp_desc_q[0], exp_sample_q, beat_idx);
                check_val("m_axis_tdata", 64'(m_axis_tdata), 64'(exp_beat.data));
                check_val("m_axis_tkeep", 64'(m_axis_tkeep), 64'(exp_beat.keep));
                check_val("m_axis_tlast", 64'(m_axis_tlast), 64'(exp_beat.last));
                held = !m_axis_tready;
                if (m_axis_tready) begin
                    beat_idx++;
                    if (beat_idx == int'(exp_desc_q[0].frame_len) + 2) begin
                        for (k = 0; k < int'(exp_desc_q[0].frame_len); k++) begin
                            void'(exp_sample_q.pop_front());
                        end
                        void'(exp_desc_q.pop_front());
                        beat_idx = 0;
                    end
                end
            end
        end
    end

    initial begin : stall_gen
        logic b0;
        logic b1;
        m_axis_tready = 1'b1;
        stall_rng     = 16'd12;
        forever begin
            @(posedge ACLK);
            #1;
            if (stall_en) begin
                b0            = stall_rng[0];
                stall_rng     = lfsr_next(stall_rng);
                b1            = stall_rng[0];
                stall_rng     = lfsr_next(stall_rng);
                m_axis_tready = b0 | b1;   // Ready about three cycles in four
            end else begin
                m_axis_tready = 1'b1;
            end
        end
    end

    initial begin : watchdog
        wait (wd_armed);
        #(wd_limit_ns);
        report_failure($sformatf("Watchdog timeout after %0d ns, the run did not finish",
                                 wd_limit_ns));
    end

    // ------------------------------------------------------------------
    // Test sequence
    // ------------------------------------------------------------------
    initial begin
        beat_t rd;
        $timeformat(-9, 0, " ns", 0);
        ARESET    = 1'b1;
        wb_cyc    = 1'b0;
        wb_stb    = 1'b0;
        wb_we     = 1'b0;
        wb_adr    = '0;
        wb_dat_i  = '0;
        adc_valid = 1'b0;
        adc_data  = '0;
        stall_en  = 1'b0;
        rng_state = 16'd12;
        choose_lengths();
        wd_armed = 1'b1;
        apply_reset();

        run_batch(0, 1);          // Single frame
        apply_reset();
        run_batch(1, 5);          // Back to back, sequence 0 to 4

        stall_en = 1'b1;
        run_batch(6, 3);
        run_batch(9, 3);
        stall_en = 1'b0;

        // Zero length request, then a normal frame
        queue_frame(chan_id_t'(rand_bits(4)), '0, line_t'(rand_bits(16)), 1'b1);
        wait_cycles(20);
        run_batch(12, 1);

        // Descriptor with no samples halts the generator
        queue_frame(4'h3, 12'd4, 16'hBEEF, 1'b0);
        wait_cycles(8);
        wb_access(1'b0, `DF_ADDR_STATUS, '0, rd);
        check_val("status.gen_error", 64'(rd[0]), 64'd1);
        write_samples(8);
        wait_cycles(40);
        apply_reset();

        write_samples(`DF_SAMPLE_DEPTH + 6);
        wb_access(1'b0, `DF_ADDR_STATUS, '0, rd);
        check_val("status.overflow", 64'(rd[1]), 64'd1);
        check_val("status.gen_error", 64'(rd[0]), 64'd0);

        $display("Everything OK");
        $finish;
    end

endmodule

`default_nettype wire

//--- sim/tb_clock.sv
`default_nettype none
`timescale 1ns/1ps

module tb_clock #(
    parameter int PERIOD_NS = 4
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever begin
            #(PERIOD_NS / 2) clk = ~clk;
        end
    end

endmodule

`default_nettype wire
